// ==== raven_io_regs.f ====
rtl/raven_io_pkg.sv
rtl/raven_io_bus_port.sv
rtl/raven_pad_route_bank.sv
rtl/raven_analog_bank.sv
rtl/raven_io_regs.sv
tests/raven_io_assertions.sv
tests/tb_raven_io_regs.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_raven_io_regs
FILELIST = raven_io_regs.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, an early stop counts as failure
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_raven_io_regs.sv ====
`timescale 1ns/1ps

/*
 * Testbench for the peripheral register block
 * Clock, reset, reset-value reads, directed and random accesses
 * Register model, pad, interrupt, ADC and analog output checks
 */
module tb_raven_io_regs;
	import raven_io_pkg::*;

	localparam int N_RANDOM = 400;
	// 400 accesses x 3 cycles plus margin
	localparam int TIMEOUT_CYCLES = 1500;
	localparam int N_OFS = 50;
	// 42 mapped offsets then 8 unmapped ones
	localparam logic [7:0] OFS_LIST [N_OFS] = '{
		8'h00, 8'h04, 8'h08, 8'h0c, 8'h10, 8'h14, 8'h18, 8'h1c, 8'h20, 8'h24,
		8'h30, 8'h34, 8'h38, 8'h3c, 8'h40, 8'h44, 8'h50, 8'h54, 8'h60, 8'h64,
		8'h68, 8'h6c, 8'h70, 8'h74, 8'h80, 8'h84, 8'h88, 8'h8c, 8'h90, 8'h94,
		8'ha0, 8'ha4, 8'ha8, 8'hb0, 8'hb4, 8'hc0, 8'hc4, 8'hc8, 8'hd0, 8'he0,
		8'he4, 8'he8, 8'h28, 8'h48, 8'h58, 8'h78, 8'h98, 8'hac, 8'hcc, 8'hfc};

	logic         clk;
	logic         resetn;
	io_req_t      req;
	io_rsp_t      rsp;
	logic [15:0]  gpio_in;
	logic [15:0]  gpio_out;
	logic [15:0]  gpio_outenb;
	mon_src_t     mon;
	logic         trap;
	logic [3:0]   irq_route;
	adc_stat_t    adc0_stat;
	adc_stat_t    adc1_stat;
	spi_ro_t      spi_ro;
	adc_clk_src_t clk_src;
	adc_ctrl_t    adc0_ctrl;
	adc_ctrl_t    adc1_ctrl;
	logic         adc0_clk;
	logic         adc1_clk;
	analog_ctrl_t analog;

	// Model word per byte offset holding writable bits only
	logic [31:0] model [256];
	int          errors;
	int          checks;
	int          cycles;

	raven_io_regs dut_i (
		.clk (clk), .resetn (resetn), .req (req), .rsp (rsp),
		.gpio_in (gpio_in), .gpio_out (gpio_out), .gpio_outenb (gpio_outenb),
		.mon (mon), .trap (trap), .irq_route (irq_route),
		.adc0_stat (adc0_stat), .adc1_stat (adc1_stat), .spi_ro (spi_ro),
		.clk_src (clk_src), .adc0_ctrl (adc0_ctrl), .adc1_ctrl (adc1_ctrl),
		.adc0_clk (adc0_clk), .adc1_clk (adc1_clk), .analog (analog)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the test did not finish", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Writable bits per offset
	// Read-only and unmapped offsets have none
	function automatic logic [31:0] writable_mask(input logic [7:0] ofs);
		case (ofs)
			8'h00, 8'h04, 8'h08, 8'h0c: return 32'h0000ffff;
			8'h54: return 32'h000003ff;
			8'h10, 8'h1c, 8'h30, 8'h3c, 8'h50, 8'h60, 8'h70,
			8'hc0, 8'hc4, 8'hc8, 8'hd0, 8'he0: return 32'h1;
			8'h20, 8'h24, 8'h40, 8'h44, 8'h64, 8'h68, 8'h6c, 8'h74,
			8'ha0, 8'ha4, 8'ha8, 8'hb0, 8'hb4, 8'he8: return 32'h3;
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	// Monitor that owns each pad
	// comp 0-1 rcosc 2-4 xtal 5-7 pll 8-10 trap 11-13 ot 14-15
	function automatic int pad_monitor(input int p);
		if (p < 2)
			return 0;
		else if (p < 5)
			return 1;
		else if (p < 8)
			return 2;
		else if (p < 11)
			return 3;
		else if (p < 14)
			return 4;
		return 5;
	endfunction

	function automatic int first_pad(input int m);
		case (m)
			0: return 0;
			1: return 2;
			2: return 5;
			3: return 8;
			4: return 11;
			default: return 14;
		endcase
	endfunction

	function automatic logic [7:0] dest_offset(input int m);
		case (m)
			0: return 8'h6c;
			1: return 8'h74;
			2: return 8'ha0;
			3: return 8'ha4;
			4: return 8'ha8;
			default: return 8'he8;
		endcase
	endfunction

	function automatic logic monitor_level(input int m);
		case (m)
			0: return mon.comp_in;
			1: return mon.rcosc_in;
			2: return mon.xtal_in;
			3: return mon.pll_clk;
			4: return trap;
			default: return mon.overtemp;
		endcase
	endfunction

	// Selected pad carries its monitor
	// Select code is the pad position in its group plus one
	function automatic logic [15:0] exp_gpio_out();
		logic [15:0] v;
		logic [1:0]  d;
		int          m;
		for (int p = 0; p < 16; p++) begin
			m = pad_monitor(p);
			d = model[dest_offset(m)][1:0];
			if (int'(d) == p - first_pad(m) + 1)
				v[p] = monitor_level(m);
			else
				v[p] = model[8'h00][p];
		end
		return v;
	endfunction

	function automatic logic [15:0] exp_gpio_outenb();
		logic [15:0] v;
		for (int p = 0; p < 16; p++)
			v[p] = (model[dest_offset(pad_monitor(p))][1:0] != 2'd0) ? 1'b0 : model[8'h04][p];
		return v;
	endfunction

	function automatic logic pick_pin(input logic [1:0] src, input int base);
		if (src == 2'd0)
			return 1'b0;
		return gpio_in[base + int'(src) - 1];
	endfunction

	function automatic logic [3:0] exp_irq();
		logic [3:0] r;
		r[0] = pick_pin(model[8'hb0][1:0], 0);
		r[1] = pick_pin(model[8'hb4][1:0], 3);
		r[2] = (model[8'h6c][1:0] == DEST_IRQ) && mon.comp_in;
		r[3] = (model[8'he8][1:0] == DEST_IRQ) && mon.overtemp;
		return r;
	endfunction

	function automatic adc_ctrl_t exp_adc_ctrl(input logic [7:0] base);
		adc_ctrl_t c;
		c.ena = model[base][0];
		c.convert = model[base + 8'h0c][0];
		c.clksrc = model[base + 8'h10][1:0];
		c.inputsrc = model[base + 8'h14][1:0];
		return c;
	endfunction

	function automatic logic exp_adc_clk(input logic [1:0] sel);
		case (sel)
			2'd0: return clk_src.rcosc_in;
			2'd1: return clk_src.spi_sck;
			2'd2: return clk_src.xtal_in;
			default: return clk_src.ext_clk;
		endcase
	endfunction

	function automatic analog_ctrl_t exp_analog();
		analog_ctrl_t a;
		a.dac_ena = model[8'h50][0];
		a.dac_value = model[8'h54][9:0];
		a.comp_ena = model[8'h60][0];
		a.comp_ninputsrc = model[8'h64][1:0];
		a.comp_pinputsrc = model[8'h68][1:0];
		a.rcosc_ena = model[8'h70][0];
		a.overtemp_ena = model[8'he0][0];
		a.analog_out_sel = model[8'hc0][0];
		a.opamp_ena = model[8'hc8][0];
		a.opamp_bias_ena = model[8'hc4][0];
		a.bg_ena = model[8'hd0][0];
		return a;
	endfunction

	// Expected read word
	// Status offsets read the live inputs
	function automatic logic [31:0] expected_read(input logic [7:0] ofs);
		case (ofs)
			8'h00: return {exp_gpio_out(), gpio_in};
			8'h14: return 32'(adc0_stat.data);
			8'h18: return 32'(adc0_stat.done);
			8'h34: return 32'(adc1_stat.data);
			8'h38: return 32'(adc1_stat.done);
			8'h80: return 32'(spi_ro.cfg);
			8'h84: return {30'd0, spi_ro.xtal_ena, spi_ro.reg_ena};
			8'h88: return {25'd0, spi_ro.pll_trim, spi_ro.pll_cp_ena,
				spi_ro.pll_vco_ena, spi_ro.pll_bias_ena};
			8'h8c: return 32'(spi_ro.mfgr_id);
			8'h90: return 32'(spi_ro.prod_id);
			8'h94: return 32'(spi_ro.mask_rev);
			8'he4: return 32'(mon.overtemp);
			default: return model[ofs];
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
		checks++;
		if (actv !== expv) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expv, actv);
		end
	endtask

	task automatic check_outputs();
		compare("gpio_out", 32'(exp_gpio_out()), 32'(gpio_out));
		compare("gpio_outenb", 32'(exp_gpio_outenb()), 32'(gpio_outenb));
		compare("irq_route", 32'(exp_irq()), 32'(irq_route));
		compare("adc0_ctrl", 32'(exp_adc_ctrl(8'h10)), 32'(adc0_ctrl));
		compare("adc1_ctrl", 32'(exp_adc_ctrl(8'h30)), 32'(adc1_ctrl));
		compare("adc0_clk", 32'(exp_adc_clk(model[8'h20][1:0])), 32'(adc0_clk));
		compare("adc1_clk", 32'(exp_adc_clk(model[8'h40][1:0])), 32'(adc1_clk));
		compare("analog", 32'(exp_analog()), 32'(analog));
	endtask

	task automatic randomize_inputs();
		gpio_in = 16'($urandom);
		mon = 5'($urandom);
		trap = 1'($urandom);
		adc0_stat = 11'($urandom);
		adc1_stat = 11'($urandom);
		spi_ro = 43'({$urandom, $urandom});
		clk_src = 4'($urandom);
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic do_access(input logic [7:0] ofs, input logic [3:0] strb,
		input logic [31:0] data);
		logic [31:0] exp_rd;
		logic [31:0] m;
		logic        ready_seen;
		int          waited;
		exp_rd = expected_read(ofs);
		m = lane_mask(strb) & writable_mask(ofs);
		req = '{valid: 1'b1, addr: {IO_PAGE, ofs}, wstrb: strb, wdata: data};
		waited = 0;
		ready_seen = 1'b0;
		while (!ready_seen && waited < 4) begin
			@(posedge clk);
			#1;
			waited++;
			ready_seen = rsp.ready;
		end
		if (!ready_seen) begin
			errors++;
			$display("No ready for the request at offset %h", ofs);
		end else begin
			if (waited != 1) begin
				errors++;
				$display("Ready came %0d cycles after accepting offset %h", waited, ofs);
			end
			compare($sformatf("rsp.rdata[%h]", ofs), exp_rd, rsp.rdata);
		end
		req.valid = 1'b0;
		// Old value returned before the strobed bytes change
		model[ofs] = (model[ofs] & ~m) | (data & m);
		@(posedge clk);
		#1;
		if (rsp.ready) begin
			errors++;
			$display("Ready stayed high a second cycle at offset %h", ofs);
		end
		check_outputs();
	endtask

	initial begin
		int          idx;
		logic [3:0]  strb;
		logic [31:0] data;
		errors = 0;
		checks = 0;
		cycles = 0;
		void'($urandom(34));
		resetn = 1'b0;
		req = '0;
		gpio_in = '0;
		mon = '0;
		trap = 1'b0;
		adc0_stat = '0;
		adc1_stat = '0;
		spi_ro = '0;
		clk_src = '0;
		for (int i = 0; i < 256; i++)
			model[i] = 32'h0;
		// All pads inputs out of reset
		model[8'h04] = 32'h0000ffff;

		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		// Reset values over the whole window
		check_outputs();
		for (int i = 0; i < 64; i++)
			do_access(8'(i * 4), 4'h0, $urandom);

		// 0x0c must show the pull-down register
		do_access(8'h08, 4'h3, 32'h0000aaaa);
		do_access(8'h0c, 4'h3, 32'h00005555);
		do_access(8'h0c, 4'h0, 32'h0);

		// Out-of-page request is never answered
		req = '{valid: 1'b1, addr: 32'h0400_0010, wstrb: 4'h0, wdata: 32'h0};
		repeat (3) begin
			@(posedge clk);
			#1;
			if (rsp.ready) begin
				errors++;
				$display("Ready answered an out-of-page request");
			end
		end
		req.valid = 1'b0;

		// Random reads and strobed writes with fresh input levels
		for (int n = 0; n < N_RANDOM; n++) begin
			randomize_inputs();
			idx = int'($urandom_range(0, N_OFS - 1));
			strb = ($urandom_range(0, 1) == 0) ? 4'h0 : 4'($urandom_range(1, 15));
			data = $urandom;
			do_access(OFS_LIST[idx], strb, data);
		end

		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tests/raven_io_assertions.sv ====
`timescale 1ns/1ps

/*
 * Handshake assertions for the bus port
 * One-cycle ready, ready after an in-page accept, ready low in reset
 */
module raven_io_assertions (
	input logic                  clk,
	input logic                  resetn,
	input raven_io_pkg::io_req_t req,
	input raven_io_pkg::io_rsp_t rsp
);
	import raven_io_pkg::*;

	// Ready is a single-cycle pulse
	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		rsp.ready |=> !rsp.ready)
		else $error("ready held high for more than one cycle");

	// Ready only after an in-page request seen while idle
	ready_after_accept: assert property (@(posedge clk) disable iff (!resetn)
		rsp.ready |-> $past(req.valid && !rsp.ready && (req.addr[31:8] == IO_PAGE)))
		else $error("ready without an accepted in-page request");

	// Reset keeps the response idle
	ready_low_in_reset: assert property (@(posedge clk)
		!resetn |=> !rsp.ready)
		else $error("ready high after a reset cycle");

endmodule

bind raven_io_bus_port raven_io_assertions assertions_i (
	.clk    (clk),
	.resetn (resetn),
	.req    (req),
	.rsp    (rsp)
);

// ==== rtl/raven_io_regs.sv ====
`timescale 1ns/1ps

/*
 * Peripheral register block top level
 * Bus port, pad routing bank and analog bank
 */
module raven_io_regs (
	input  logic                                 clk,
	input  logic                                 resetn,
	input  raven_io_pkg::io_req_t                req,
	output raven_io_pkg::io_rsp_t                rsp,
	input  logic [raven_io_pkg::GPIO_W-1:0]      gpio_in,
	output logic [raven_io_pkg::GPIO_W-1:0]      gpio_out,
	output logic [raven_io_pkg::GPIO_W-1:0]      gpio_outenb,
	input  raven_io_pkg::mon_src_t               mon,
	input  logic                                 trap,
	output logic [raven_io_pkg::IRQ_ROUTE_W-1:0] irq_route,
	input  raven_io_pkg::adc_stat_t              adc0_stat,
	input  raven_io_pkg::adc_stat_t              adc1_stat,
	input  raven_io_pkg::spi_ro_t                spi_ro,
	input  raven_io_pkg::adc_clk_src_t           clk_src,
	output raven_io_pkg::adc_ctrl_t              adc0_ctrl,
	output raven_io_pkg::adc_ctrl_t              adc1_ctrl,
	output logic                                 adc0_clk,
	output logic                                 adc1_clk,
	output raven_io_pkg::analog_ctrl_t           analog
);
	import raven_io_pkg::*;

	// Shared access and per-bank replies
	io_access_t access;
	bank_rsp_t  route_rsp;
	bank_rsp_t  analog_rsp;

	raven_io_bus_port bus_port_i (
		.clk        (clk),
		.resetn     (resetn),
		.req        (req),
		.route_rsp  (route_rsp),
		.analog_rsp (analog_rsp),
		.access     (access),
		.rsp        (rsp)
	);

	raven_pad_route_bank pad_route_i (
		.clk         (clk),
		.resetn      (resetn),
		.access      (access),
		.gpio_in     (gpio_in),
		.mon         (mon),
		.trap        (trap),
		.rsp         (route_rsp),
		.gpio_out    (gpio_out),
		.gpio_outenb (gpio_outenb),
		.irq_route   (irq_route)
	);

	// Overtemp status read from the monitor input
	raven_analog_bank analog_i (
		.clk       (clk),
		.resetn    (resetn),
		.access    (access),
		.adc0_stat (adc0_stat),
		.adc1_stat (adc1_stat),
		.spi_ro    (spi_ro),
		.overtemp  (mon.overtemp),
		.clk_src   (clk_src),
		.rsp       (analog_rsp),
		.adc0_ctrl (adc0_ctrl),
		.adc1_ctrl (adc1_ctrl),
		.adc0_clk  (adc0_clk),
		.adc1_clk  (adc1_clk),
		.analog    (analog)
	);

endmodule

// ==== rtl/raven_analog_bank.sv ====
`timescale 1ns/1ps

/*
 * Analog control bank
 * ADC, DAC, comparator, RC oscillator, output path and overtemp controls
 * Read-only ADC status, SPI configuration and overtemp words
 * ADC clock source multiplexers
 */
module raven_analog_bank (
	input  logic                       clk,
	input  logic                       resetn,
	input  raven_io_pkg::io_access_t   access,
	input  raven_io_pkg::adc_stat_t    adc0_stat,
	input  raven_io_pkg::adc_stat_t    adc1_stat,
	input  raven_io_pkg::spi_ro_t      spi_ro,
	input  logic                       overtemp,
	input  raven_io_pkg::adc_clk_src_t clk_src,
	output raven_io_pkg::bank_rsp_t    rsp,
	output raven_io_pkg::adc_ctrl_t    adc0_ctrl,
	output raven_io_pkg::adc_ctrl_t    adc1_ctrl,
	output logic                       adc0_clk,
	output logic                       adc1_clk,
	output raven_io_pkg::analog_ctrl_t analog
);
	import raven_io_pkg::*;

	adc_ctrl_t        adc_ctrl_q [ADC_N];
	analog_ctrl_t     ana_q;
	adc_stat_t        adc_stat [ADC_N];
	logic [ADC_N-1:0] adc_clk;
	logic [15:0]      dac_mask;

	assign adc_stat[0] = adc0_stat;
	assign adc_stat[1] = adc1_stat;
	assign dac_mask = half_mask(access.wstrb[1:0]);

	// ADC clock: RC osc, SPI clock, crystal or external
	always_comb begin
		for (int i = 0; i < ADC_N; i++) begin
			case (adc_ctrl_q[i].clksrc)
				2'd0:    adc_clk[i] = clk_src.rcosc_in;
				2'd1:    adc_clk[i] = clk_src.spi_sck;
				2'd2:    adc_clk[i] = clk_src.xtal_in;
				default: adc_clk[i] = clk_src.ext_clk;
			endcase
		end
	end

	assign adc0_ctrl = adc_ctrl_q[0];
	assign adc1_ctrl = adc_ctrl_q[1];
	assign adc0_clk = adc_clk[0];
	assign adc1_clk = adc_clk[1];
	assign analog = ana_q;

	// Read decode for control and status words
	always_comb begin
		rsp = '{hit: 1'b1, rdata: '0};
		case (access.offset)
			REG_DAC_ENA:      rsp.rdata[0] = ana_q.dac_ena;
			REG_DAC_VALUE:    rsp.rdata[ADC_W-1:0] = ana_q.dac_value;
			REG_COMP_ENA:     rsp.rdata[0] = ana_q.comp_ena;
			REG_COMP_NSRC:    rsp.rdata[SEL_W-1:0] = ana_q.comp_ninputsrc;
			REG_COMP_PSRC:    rsp.rdata[SEL_W-1:0] = ana_q.comp_pinputsrc;
			REG_RCOSC_ENA:    rsp.rdata[0] = ana_q.rcosc_ena;
			REG_SPI_CONFIG:   rsp.rdata[7:0] = spi_ro.cfg;
			REG_SPI_XTAL_REG: rsp.rdata[1:0] = {spi_ro.xtal_ena, spi_ro.reg_ena};
			// Trim above the three PLL enables
			REG_SPI_PLL:      rsp.rdata[6:0] = {spi_ro.pll_trim, spi_ro.pll_cp_ena,
				spi_ro.pll_vco_ena, spi_ro.pll_bias_ena};
			REG_SPI_MFGR:     rsp.rdata[11:0] = spi_ro.mfgr_id;
			REG_SPI_PROD:     rsp.rdata[7:0] = spi_ro.prod_id;
			REG_SPI_MASK:     rsp.rdata[3:0] = spi_ro.mask_rev;
			REG_ANALOG_SEL:   rsp.rdata[0] = ana_q.analog_out_sel;
			REG_OPAMP_BIAS:   rsp.rdata[0] = ana_q.opamp_bias_ena;
			REG_OPAMP_ENA:    rsp.rdata[0] = ana_q.opamp_ena;
			REG_BG_ENA:       rsp.rdata[0] = ana_q.bg_ena;
			REG_OT_ENA:       rsp.rdata[0] = ana_q.overtemp_ena;
			// Live alarm level
			REG_OT_DATA:      rsp.rdata[0] = overtemp;
			default:          rsp.hit = 1'b0;
		endcase
		// Per-ADC words, same layout at both bases
		for (int i = 0; i < ADC_N; i++) begin
			case (access.offset)
				ADC_ENA_OFS[i]:    rsp = '{hit: 1'b1, rdata: 32'(adc_ctrl_q[i].ena)};
				ADC_DATA_OFS[i]:   rsp = '{hit: 1'b1, rdata: 32'(adc_stat[i].data)};
				ADC_DONE_OFS[i]:   rsp = '{hit: 1'b1, rdata: 32'(adc_stat[i].done)};
				ADC_CONV_OFS[i]:   rsp = '{hit: 1'b1, rdata: 32'(adc_ctrl_q[i].convert)};
				ADC_CLKSRC_OFS[i]: rsp = '{hit: 1'b1, rdata: 32'(adc_ctrl_q[i].clksrc)};
				ADC_INSRC_OFS[i]:  rsp = '{hit: 1'b1, rdata: 32'(adc_ctrl_q[i].inputsrc)};
				default: ;
			endcase
		end
	end

	// Read-only offsets have no write path
	always_ff @(posedge clk) begin
		if (!resetn) begin
			adc_ctrl_q <= '{default: '0};
			ana_q <= '0;
		end else if (access.strobe) begin
			// DAC value spans two byte lanes
			if (access.offset == REG_DAC_VALUE)
				ana_q.dac_value <= (ana_q.dac_value & ~dac_mask[ADC_W-1:0]) |
					(access.wdata[ADC_W-1:0] & dac_mask[ADC_W-1:0]);
			if (access.wstrb[0]) begin
				case (access.offset)
					REG_DAC_ENA:    ana_q.dac_ena <= access.wdata[0];
					REG_COMP_ENA:   ana_q.comp_ena <= access.wdata[0];
					REG_COMP_NSRC:  ana_q.comp_ninputsrc <= access.wdata[SEL_W-1:0];
					REG_COMP_PSRC:  ana_q.comp_pinputsrc <= access.wdata[SEL_W-1:0];
					REG_RCOSC_ENA:  ana_q.rcosc_ena <= access.wdata[0];
					REG_ANALOG_SEL: ana_q.analog_out_sel <= access.wdata[0];
					REG_OPAMP_BIAS: ana_q.opamp_bias_ena <= access.wdata[0];
					REG_OPAMP_ENA:  ana_q.opamp_ena <= access.wdata[0];
					REG_BG_ENA:     ana_q.bg_ena <= access.wdata[0];
					REG_OT_ENA:     ana_q.overtemp_ena <= access.wdata[0];
					default: ;
				endcase
				for (int i = 0; i < ADC_N; i++) begin
					case (access.offset)
						ADC_ENA_OFS[i]:    adc_ctrl_q[i].ena <= access.wdata[0];
						ADC_CONV_OFS[i]:   adc_ctrl_q[i].convert <= access.wdata[0];
						ADC_CLKSRC_OFS[i]: adc_ctrl_q[i].clksrc <= access.wdata[SEL_W-1:0];
						ADC_INSRC_OFS[i]:  adc_ctrl_q[i].inputsrc <= access.wdata[SEL_W-1:0];
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== rtl/raven_pad_route_bank.sv ====
`timescale 1ns/1ps

/*
 * Pad routing bank
 * GPIO data, oeb, pull-up and pull-down registers
 * Monitor destination and IRQ 7/8 source registers
 * Pad output and enable multiplexers, routed interrupts
 */
module raven_pad_route_bank (
	input  logic                                 clk,
	input  logic                                 resetn,
	input  raven_io_pkg::io_access_t             access,
	input  logic [raven_io_pkg::GPIO_W-1:0]      gpio_in,
	input  raven_io_pkg::mon_src_t               mon,
	input  logic                                 trap,
	output raven_io_pkg::bank_rsp_t              rsp,
	output logic [raven_io_pkg::GPIO_W-1:0]      gpio_out,
	output logic [raven_io_pkg::GPIO_W-1:0]      gpio_outenb,
	output logic [raven_io_pkg::IRQ_ROUTE_W-1:0] irq_route
);
	import raven_io_pkg::*;

	logic [GPIO_W-1:0] gpio_q;
	// Output enable, active low
	logic [GPIO_W-1:0] oeb_q;
	// Pull registers, readable only
	logic [GPIO_W-1:0] pu_q;
	logic [GPIO_W-1:0] pd_q;
	logic [SEL_W-1:0]  dest_q [MON_N];
	logic [SEL_W-1:0]  irq_src_q [IRQ_SRC_N];
	logic [MON_N-1:0]  mon_bit;
	logic [GPIO_W-1:0] keep_half;
	logic [GPIO_W-1:0] new_half;

	// Byte lanes of a 16-bit write
	assign keep_half = ~half_mask(access.wstrb[1:0]);
	assign new_half = access.wdata[GPIO_W-1:0] & half_mask(access.wstrb[1:0]);

	// Monitor sources in destination-register order
	assign mon_bit[MON_COMP] = mon.comp_in;
	assign mon_bit[MON_RCOSC] = mon.rcosc_in;
	assign mon_bit[MON_XTAL] = mon.xtal_in;
	// PLL clock also on the third PLL pad
	assign mon_bit[MON_PLL] = mon.pll_clk;
	assign mon_bit[MON_TRAP] = trap;
	assign mon_bit[MON_OT] = mon.overtemp;

	// Pad shows its monitor when selected, else its data bit
	// Any nonzero destination drives the whole group
	for (genvar p = 0; p < GPIO_W; p++) begin : g_pad
		assign gpio_out[p] = (dest_q[PIN_MON[p]] == SEL_W'(PIN_CODE[p])) ?
			mon_bit[PIN_MON[p]] : gpio_q[p];
		assign gpio_outenb[p] = (dest_q[PIN_MON[p]] != '0) ? 1'b0 : oeb_q[p];
	end

	// IRQ 7 picks pin 0/1/2, IRQ 8 pin 3/4/5
	always_comb begin
		for (int k = 0; k < IRQ_SRC_N; k++) begin
			case (irq_src_q[k])
				2'd1:    irq_route[k] = gpio_in[3*k];
				2'd2:    irq_route[k] = gpio_in[3*k+1];
				2'd3:    irq_route[k] = gpio_in[3*k+2];
				default: irq_route[k] = 1'b0;
			endcase
		end
		// IRQ 9 and 10 when the destination is the interrupt code
		irq_route[2] = (dest_q[MON_COMP] == DEST_IRQ) && mon.comp_in;
		irq_route[3] = (dest_q[MON_OT] == DEST_IRQ) && mon.overtemp;
	end

	// Read decode, from state before any write
	always_comb begin
		rsp = '{hit: 1'b1, rdata: '0};
		case (access.offset)
			REG_GPIO_DATA: rsp.rdata = {gpio_out, gpio_in};
			REG_GPIO_OEB:  rsp.rdata[GPIO_W-1:0] = oeb_q;
			REG_GPIO_PU:   rsp.rdata[GPIO_W-1:0] = pu_q;
			// 0x0c returns the pull-down register
			REG_GPIO_PD:   rsp.rdata[GPIO_W-1:0] = pd_q;
			default:       rsp.hit = 1'b0;
		endcase
		for (int k = 0; k < MON_N; k++) begin
			if (access.offset == MON_DEST_OFS[k])
				rsp = '{hit: 1'b1, rdata: 32'(dest_q[k])};
		end
		for (int k = 0; k < IRQ_SRC_N; k++) begin
			if (access.offset == IRQ_SRC_OFS[k])
				rsp = '{hit: 1'b1, rdata: 32'(irq_src_q[k])};
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gpio_q <= '0;
			oeb_q <= OEB_RESET;
			pu_q <= '0;
			pd_q <= '0;
			dest_q <= '{default: '0};
			irq_src_q <= '{default: '0};
		end else if (access.strobe) begin
			// GPIO words take both low byte lanes
			case (access.offset)
				REG_GPIO_DATA: gpio_q <= (gpio_q & keep_half) | new_half;
				REG_GPIO_OEB:  oeb_q <= (oeb_q & keep_half) | new_half;
				REG_GPIO_PU:   pu_q <= (pu_q & keep_half) | new_half;
				REG_GPIO_PD:   pd_q <= (pd_q & keep_half) | new_half;
				default: ;
			endcase
			// Select fields live in byte 0
			if (access.wstrb[0]) begin
				for (int k = 0; k < MON_N; k++) begin
					if (access.offset == MON_DEST_OFS[k])
						dest_q[k] <= access.wdata[SEL_W-1:0];
				end
				for (int k = 0; k < IRQ_SRC_N; k++) begin
					if (access.offset == IRQ_SRC_OFS[k])
						irq_src_q[k] <= access.wdata[SEL_W-1:0];
				end
			end
		end
	end

endmodule

// ==== rtl/raven_io_bus_port.sv ====
`timescale 1ns/1ps

/*
 * Bus port of the peripheral register block
 * Page check and accept, access broadcast to the banks
 * Registered one-cycle ready and merged read word
 */
module raven_io_bus_port (
	input  logic                     clk,
	input  logic                     resetn,
	input  raven_io_pkg::io_req_t    req,
	input  raven_io_pkg::bank_rsp_t  route_rsp,
	input  raven_io_pkg::bank_rsp_t  analog_rsp,
	output raven_io_pkg::io_access_t access,
	output raven_io_pkg::io_rsp_t    rsp
);
	import raven_io_pkg::*;

	logic        accept;
	logic        ready_q;
	logic [31:0] rdata_d;
	logic [31:0] rdata_q;

	// In-page request not being answered right now
	// Out-of-page requests never see ready
	assign accept = req.valid && !ready_q && (req.addr[31:8] == IO_PAGE);

	// Strobe only in the accept cycle
	assign access = '{
		strobe: accept,
		offset: req.addr[7:0],
		wstrb:  req.wstrb,
		wdata:  req.wdata
	};

	// At most one bank owns an offset
	// Unmapped offsets read as zero
	always_comb begin
		if (route_rsp.hit)
			rdata_d = route_rsp.rdata;
		else if (analog_rsp.hit)
			rdata_d = analog_rsp.rdata;
		else
			rdata_d = '0;
	end

	// One-cycle ready pulse after accept
	always_ff @(posedge clk) begin
		if (!resetn)
			ready_q <= 1'b0;
		else
			ready_q <= accept;
	end

	// Read word captured with the old register state
	always_ff @(posedge clk) begin
		if (accept)
			rdata_q <= rdata_d;
	end

	assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== rtl/raven_io_pkg.sv ====
/*
 * Shared definitions for the peripheral register block
 * Window page, field widths, register byte offsets and offset tables
 * Bus, bank, ADC, analog, SPI and monitor packed struct types
 * Byte-lane mask helper for the 16-bit registers
 */
package raven_io_pkg;

	// Upper 24 address bits of the 256-byte window
	localparam logic [23:0] IO_PAGE = 24'h030000;

	localparam int GPIO_W = 16;
	localparam int ADC_W = 10;
	localparam int SEL_W = 2;
	localparam int ADC_N = 2;
	localparam int MON_N = 6;
	localparam int IRQ_SRC_N = 2;
	// IRQ 7, 8, 9, 10 in bits 0 to 3
	localparam int IRQ_ROUTE_W = 4;

	// Destination code that goes to an interrupt, not a pad
	localparam logic [SEL_W-1:0] DEST_IRQ = 2'd3;
	// All pads start as inputs
	localparam logic [GPIO_W-1:0] OEB_RESET = '1;

	// GPIO
	localparam logic [7:0] REG_GPIO_DATA = 8'h00;
	localparam logic [7:0] REG_GPIO_OEB = 8'h04;
	localparam logic [7:0] REG_GPIO_PU = 8'h08;
	localparam logic [7:0] REG_GPIO_PD = 8'h0c;
	// ADC0
	localparam logic [7:0] REG_ADC0_ENA = 8'h10;
	localparam logic [7:0] REG_ADC0_DATA = 8'h14;
	localparam logic [7:0] REG_ADC0_DONE = 8'h18;
	localparam logic [7:0] REG_ADC0_CONVERT = 8'h1c;
	localparam logic [7:0] REG_ADC0_CLKSRC = 8'h20;
	localparam logic [7:0] REG_ADC0_INSRC = 8'h24;
	// ADC1
	localparam logic [7:0] REG_ADC1_ENA = 8'h30;
	localparam logic [7:0] REG_ADC1_DATA = 8'h34;
	localparam logic [7:0] REG_ADC1_DONE = 8'h38;
	localparam logic [7:0] REG_ADC1_CONVERT = 8'h3c;
	localparam logic [7:0] REG_ADC1_CLKSRC = 8'h40;
	localparam logic [7:0] REG_ADC1_INSRC = 8'h44;
	// DAC and comparator
	localparam logic [7:0] REG_DAC_ENA = 8'h50;
	localparam logic [7:0] REG_DAC_VALUE = 8'h54;
	localparam logic [7:0] REG_COMP_ENA = 8'h60;
	localparam logic [7:0] REG_COMP_NSRC = 8'h64;
	localparam logic [7:0] REG_COMP_PSRC = 8'h68;
	localparam logic [7:0] REG_COMP_DEST = 8'h6c;
	// RC oscillator
	localparam logic [7:0] REG_RCOSC_ENA = 8'h70;
	localparam logic [7:0] REG_RCOSC_DEST = 8'h74;
	// Read-only words from the standalone SPI
	localparam logic [7:0] REG_SPI_CONFIG = 8'h80;
	localparam logic [7:0] REG_SPI_XTAL_REG = 8'h84;
	localparam logic [7:0] REG_SPI_PLL = 8'h88;
	localparam logic [7:0] REG_SPI_MFGR = 8'h8c;
	localparam logic [7:0] REG_SPI_PROD = 8'h90;
	localparam logic [7:0] REG_SPI_MASK = 8'h94;
	// Monitor destinations and IRQ sources
	localparam logic [7:0] REG_XTAL_DEST = 8'ha0;
	localparam logic [7:0] REG_PLL_DEST = 8'ha4;
	localparam logic [7:0] REG_TRAP_DEST = 8'ha8;
	localparam logic [7:0] REG_IRQ7_SRC = 8'hb0;
	localparam logic [7:0] REG_IRQ8_SRC = 8'hb4;
	// Analog output path
	localparam logic [7:0] REG_ANALOG_SEL = 8'hc0;
	localparam logic [7:0] REG_OPAMP_BIAS = 8'hc4;
	localparam logic [7:0] REG_OPAMP_ENA = 8'hc8;
	localparam logic [7:0] REG_BG_ENA = 8'hd0;
	// Over-temperature alarm
	localparam logic [7:0] REG_OT_ENA = 8'he0;
	localparam logic [7:0] REG_OT_DATA = 8'he4;
	localparam logic [7:0] REG_OT_DEST = 8'he8;

	// Per-ADC offset tables, index 0 is ADC0
	localparam logic [7:0] ADC_ENA_OFS [ADC_N] = '{REG_ADC0_ENA, REG_ADC1_ENA};
	localparam logic [7:0] ADC_DATA_OFS [ADC_N] = '{REG_ADC0_DATA, REG_ADC1_DATA};
	localparam logic [7:0] ADC_DONE_OFS [ADC_N] = '{REG_ADC0_DONE, REG_ADC1_DONE};
	localparam logic [7:0] ADC_CONV_OFS [ADC_N] = '{REG_ADC0_CONVERT, REG_ADC1_CONVERT};
	localparam logic [7:0] ADC_CLKSRC_OFS [ADC_N] = '{REG_ADC0_CLKSRC, REG_ADC1_CLKSRC};
	localparam logic [7:0] ADC_INSRC_OFS [ADC_N] = '{REG_ADC0_INSRC, REG_ADC1_INSRC};

	// Monitored signals, one destination register each
	localparam int MON_COMP = 0;
	localparam int MON_RCOSC = 1;
	localparam int MON_XTAL = 2;
	localparam int MON_PLL = 3;
	localparam int MON_TRAP = 4;
	localparam int MON_OT = 5;
	localparam logic [7:0] MON_DEST_OFS [MON_N] = '{REG_COMP_DEST, REG_RCOSC_DEST,
		REG_XTAL_DEST, REG_PLL_DEST, REG_TRAP_DEST, REG_OT_DEST};
	localparam logic [7:0] IRQ_SRC_OFS [IRQ_SRC_N] = '{REG_IRQ7_SRC, REG_IRQ8_SRC};

	// Pad map, the monitor that owns each pad and its selecting code
	localparam int PIN_MON [GPIO_W] = '{0, 0, 1, 1, 1, 2, 2, 2, 3, 3, 3, 4, 4, 4, 5, 5};
	localparam int PIN_CODE [GPIO_W] = '{1, 2, 1, 2, 3, 1, 2, 3, 1, 2, 3, 1, 2, 3, 1, 2};

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [3:0]  wstrb;
		logic [31:0] wdata;
	} io_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} io_rsp_t;

	// Access accepted this cycle, seen by both banks
	typedef struct packed {
		logic        strobe;
		logic [7:0]  offset;
		logic [3:0]  wstrb;
		logic [31:0] wdata;
	} io_access_t;

	typedef struct packed {
		logic        hit;
		logic [31:0] rdata;
	} bank_rsp_t;

	typedef struct packed {
		logic             ena;
		logic             convert;
		logic [SEL_W-1:0] clksrc;
		logic [SEL_W-1:0] inputsrc;
	} adc_ctrl_t;

	typedef struct packed {
		logic [ADC_W-1:0] data;
		logic             done;
	} adc_stat_t;

	typedef struct packed {
		logic             dac_ena;
		logic [ADC_W-1:0] dac_value;
		logic             comp_ena;
		logic [SEL_W-1:0] comp_ninputsrc;
		logic [SEL_W-1:0] comp_pinputsrc;
		logic             rcosc_ena;
		logic             overtemp_ena;
		logic             analog_out_sel;
		logic             opamp_ena;
		logic             opamp_bias_ena;
		logic             bg_ena;
	} analog_ctrl_t;

	// Configuration held by the standalone SPI
	typedef struct packed {
		logic [7:0]  cfg;
		logic        xtal_ena;
		logic        reg_ena;
		logic        pll_cp_ena;
		logic        pll_vco_ena;
		logic        pll_bias_ena;
		logic [3:0]  pll_trim;
		logic [11:0] mfgr_id;
		logic [7:0]  prod_id;
		logic [3:0]  mask_rev;
	} spi_ro_t;

	// Live signals the pad monitors can carry
	typedef struct packed {
		logic comp_in;
		logic rcosc_in;
		logic xtal_in;
		logic pll_clk;
		logic overtemp;
	} mon_src_t;

	typedef struct packed {
		logic rcosc_in;
		logic spi_sck;
		logic xtal_in;
		logic ext_clk;
	} adc_clk_src_t;

	// Lane mask for the two low bytes
	function automatic logic [15:0] half_mask(input logic [1:0] wstrb);
		return {{8{wstrb[1]}}, {8{wstrb[0]}}};
	endfunction

endpackage
